/* rtl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
   decodeIf.dp       ctrl,
   input wire word_t pc_i,
   input wire word_t rs1Data_i,
   input wire word_t rs2Data_i,
   output word_t     aluOut_o,
   output logic      aluEq_o,
   output logic      aluLt_o,
   output logic      aluLtu_o
);

   word_t      opA;
   word_t      opB;
   logic [4:0] shamt;

   assign opA   = ctrl.srcAPc ? pc_i : rs1Data_i;
   assign opB   = ctrl.srcBImm ? ctrl.imm : rs2Data_i;
   assign shamt = opB[4:0];

   always_comb begin
      case (ctrl.aluOp)
         AluAdd:   aluOut_o = opA + opB;
         AluSub:   aluOut_o = opA - opB;
         AluSll:   aluOut_o = opA << shamt;
         AluSlt:   aluOut_o = {31'b0, $signed(opA) < $signed(opB)};
         AluSltu:  aluOut_o = {31'b0, opA < opB};
         AluXor:   aluOut_o = opA ^ opB;
         AluSrl:   aluOut_o = opA >> shamt;
         AluSra:   aluOut_o = word_t'($signed(opA) >>> shamt);
         AluOr:    aluOut_o = opA | opB;
         AluAnd:   aluOut_o = opA & opB;
         AluPassB: aluOut_o = opB;
         default:  aluOut_o = opA + opB;
      endcase
   end

   // branch flags always compare the two registers
   assign aluEq_o  = (rs1Data_i == rs2Data_i);
   assign aluLt_o  = ($signed(rs1Data_i) < $signed(rs2Data_i));
   assign aluLtu_o = (rs1Data_i < rs2Data_i);

endmodule

`default_nettype wire

/* rtl/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop import rvPkg::*; #(
   parameter word_t ResetVector = 32'h80000000
) (
   input wire        clk,
   input wire        rst_n,
   input wire word_t instr_i,
   input wire word_t dmemRdata_i,
   output word_t     instrAddr_o,
   output word_t     dmemAddr_o,
   output word_t     dmemWdata_o,
   output logic      dmemWr_o
);

   decodeIf ctrl ();

   word_t pc;
   word_t rs1Data;
   word_t rs2Data;
   word_t aluOut;
   word_t csrRdData;
   word_t trapTarget;
   word_t wbData;
   logic  aluEq;
   logic  aluLt;
   logic  aluLtu;
   logic  trapTaken;

   instrDecoder i_instrDecoder (
      .instr_i (instr_i),
      .ctrl    (ctrl.dec)
   );

   regFile i_regFile (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctrl      (ctrl.dp),
      .wbData_i  (wbData),
      .rs1Data_o (rs1Data),
      .rs2Data_o (rs2Data)
   );

   aluUnit i_aluUnit (
      .ctrl      (ctrl.dp),
      .pc_i      (pc),
      .rs1Data_i (rs1Data),
      .rs2Data_i (rs2Data),
      .aluOut_o  (aluOut),
      .aluEq_o   (aluEq),
      .aluLt_o   (aluLt),
      .aluLtu_o  (aluLtu)
   );

   csrFile i_csrFile (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctrl         (ctrl.dp),
      .pc_i         (pc),
      .rs1Data_i    (rs1Data),
      .csrRdData_o  (csrRdData),
      .trapTaken_o  (trapTaken),
      .trapTarget_o (trapTarget)
   );

   pcUnit #(
      .ResetVector (ResetVector)
   ) i_pcUnit (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctrl         (ctrl.dp),
      .rs1Data_i    (rs1Data),
      .aluEq_i      (aluEq),
      .aluLt_i      (aluLt),
      .aluLtu_i     (aluLtu),
      .trapTaken_i  (trapTaken),
      .trapTarget_i (trapTarget),
      .pc_o         (pc)
   );

   // write-back source
   always_comb begin
      case (ctrl.wbSel)
         WbMem:   wbData = dmemRdata_i;
         WbPc4:   wbData = pc + 32'd4;
         WbCsr:   wbData = csrRdData;
         default: wbData = aluOut;
      endcase
   end

   assign instrAddr_o = pc;
   assign dmemAddr_o  = aluOut;
   assign dmemWdata_o = rs2Data;
   // fetch during reset is not valid, so no store may leave the core
   assign dmemWr_o    = ctrl.memWr && rst_n;

endmodule

`default_nettype wire

/* rtl/csrFile.sv */
`timescale 1ns/1ps
`default_nettype none

module csrFile import rvPkg::*; (
   input wire        clk,
   input wire        rst_n,
   decodeIf.dp       ctrl,
   input wire word_t pc_i,
   input wire word_t rs1Data_i,
   output word_t     csrRdData_o,
   output logic      trapTaken_o,
   output word_t     trapTarget_o
);

   localparam int MieBit = 3;

   word_t mtvec;
   word_t mepc;
   word_t mcause;
   logic  mie;
   word_t mstatus;
   word_t csrOld;
   word_t csrNew;

   // only MIE is implemented in mstatus
   always_comb begin
      mstatus         = '0;
      mstatus[MieBit] = mie;
   end

   always_comb begin
      case (ctrl.csrAddr)
         CsrMstatus: csrOld = mstatus;
         CsrMtvec:   csrOld = mtvec;
         CsrMepc:    csrOld = mepc;
         CsrMcause:  csrOld = mcause;
         default:    csrOld = '0;
      endcase
   end

   // csrrs sets bits, csrrw replaces
   assign csrNew      = ctrl.csrSet ? (csrOld | rs1Data_i) : rs1Data_i;
   assign csrRdData_o = csrOld;

   assign trapTaken_o  = ctrl.ecall | ctrl.mret;
   assign trapTarget_o = ctrl.ecall ? mtvec : mepc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mtvec  <= '0;
         mepc   <= '0;
         mcause <= '0;
         mie    <= 1'b0;
      end else if (ctrl.ecall) begin
         mepc   <= pc_i;
         mcause <= CauseEcallM;
         mie    <= 1'b0;
      end else if (ctrl.mret) begin
         mie <= 1'b1;
      end else if (ctrl.csrWrEn) begin
         case (ctrl.csrAddr)
            CsrMstatus: mie    <= csrNew[MieBit];
            CsrMtvec:   mtvec  <= csrNew;
            CsrMepc:    mepc   <= csrNew;
            CsrMcause:  mcause <= csrNew;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/decodeIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeIf import rvPkg::*; ();

   regAddr_t rs1Addr;
   regAddr_t rs2Addr;
   regAddr_t rdAddr;
   word_t    imm;
   aluOp_t   aluOp;
   logic     srcAPc;
   logic     srcBImm;
   branch_t  branch;
   logic     regWrEn;
   wbSel_t   wbSel;
   logic     memWr;
   csrAddr_t csrAddr;
   logic     csrWrEn;
   logic     csrSet;
   logic     ecall;
   logic     mret;

   // decoder side
   modport dec (
      output rs1Addr, rs2Addr, rdAddr, imm, aluOp, srcAPc, srcBImm, branch,
      output regWrEn, wbSel, memWr, csrAddr, csrWrEn, csrSet, ecall, mret
   );

   // datapath side
   modport dp (
      input rs1Addr, rs2Addr, rdAddr, imm, aluOp, srcAPc, srcBImm, branch,
      input regWrEn, wbSel, memWr, csrAddr, csrWrEn, csrSet, ecall, mret
   );

endinterface

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import rvPkg::*; (
   input wire word_t instr_i,
   decodeIf.dec      ctrl
);

   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpAuipc  = 7'b0010111;
   localparam logic [6:0] OpJal    = 7'b1101111;
   localparam logic [6:0] OpJalr   = 7'b1100111;
   localparam logic [6:0] OpBranch = 7'b1100011;
   localparam logic [6:0] OpLoad   = 7'b0000011;
   localparam logic [6:0] OpStore  = 7'b0100011;
   localparam logic [6:0] OpImm    = 7'b0010011;
   localparam logic [6:0] OpReg    = 7'b0110011;
   localparam logic [6:0] OpSystem = 7'b1110011;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7Alt;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;

   // shared by reg-reg and reg-imm forms
   function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? AluSub : AluAdd;
         3'b001:  return AluSll;
         3'b010:  return AluSlt;
         3'b011:  return AluSltu;
         3'b100:  return AluXor;
         3'b101:  return alt ? AluSra : AluSrl;
         3'b110:  return AluOr;
         default: return AluAnd;
      endcase
   endfunction

   assign opcode    = instr_i[6:0];
   assign funct3    = instr_i[14:12];
   assign funct7Alt = instr_i[30];

   assign ctrl.rs1Addr = instr_i[19:15];
   assign ctrl.rs2Addr = instr_i[24:20];
   assign ctrl.rdAddr  = instr_i[11:7];
   assign ctrl.csrAddr = instr_i[31:20];

   // sign-extended immediates of every format
   assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
   assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
   assign immU = {instr_i[31:12], 12'b0};
   assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

   always_comb begin
      // defaults decode as a no-op
      ctrl.imm     = immI;
      ctrl.aluOp   = AluAdd;
      ctrl.srcAPc  = 1'b0;
      ctrl.srcBImm = 1'b0;
      ctrl.branch  = BrNone;
      ctrl.regWrEn = 1'b0;
      ctrl.wbSel   = WbAlu;
      ctrl.memWr   = 1'b0;
      ctrl.csrWrEn = 1'b0;
      ctrl.csrSet  = 1'b0;
      ctrl.ecall   = 1'b0;
      ctrl.mret    = 1'b0;
      case (opcode)
         OpLui: begin
            ctrl.imm     = immU;
            ctrl.aluOp   = AluPassB;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrEn = 1'b1;
         end
         OpAuipc: begin
            ctrl.imm     = immU;
            ctrl.srcAPc  = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.regWrEn = 1'b1;
         end
         OpJal: begin
            // srcAPc tells the pc unit this jump is pc relative
            ctrl.imm     = immJ;
            ctrl.srcAPc  = 1'b1;
            ctrl.srcBImm = 1'b1;
            ctrl.branch  = BrJump;
            ctrl.regWrEn = 1'b1;
            ctrl.wbSel   = WbPc4;
         end
         OpJalr: begin
            if (funct3 == 3'b000) begin
               ctrl.srcBImm = 1'b1;
               ctrl.branch  = BrJump;
               ctrl.regWrEn = 1'b1;
               ctrl.wbSel   = WbPc4;
            end
         end
         OpBranch: begin
            ctrl.imm   = immB;
            ctrl.aluOp = AluSub;
            case (funct3)
               3'b000:  ctrl.branch = BrEq;
               3'b001:  ctrl.branch = BrNe;
               3'b100:  ctrl.branch = BrLt;
               3'b101:  ctrl.branch = BrGe;
               3'b110:  ctrl.branch = BrLtu;
               3'b111:  ctrl.branch = BrGeu;
               default: ctrl.branch = BrNone;
            endcase
         end
         OpLoad: begin
            // word access only
            if (funct3 == 3'b010) begin
               ctrl.srcBImm = 1'b1;
               ctrl.regWrEn = 1'b1;
               ctrl.wbSel   = WbMem;
            end
         end
         OpStore: begin
            if (funct3 == 3'b010) begin
               ctrl.imm     = immS;
               ctrl.srcBImm = 1'b1;
               ctrl.memWr   = 1'b1;
            end
         end
         OpImm: begin
            ctrl.srcBImm = 1'b1;
            ctrl.regWrEn = 1'b1;
            ctrl.aluOp   = aluFromFunct(funct3, (funct3 == 3'b101) && funct7Alt);
         end
         OpReg: begin
            ctrl.regWrEn = 1'b1;
            ctrl.aluOp   = aluFromFunct(funct3, funct7Alt);
         end
         OpSystem: begin
            case (funct3)
               3'b000: begin
                  ctrl.ecall = (instr_i[31:20] == 12'h000);
                  ctrl.mret  = (instr_i[31:20] == 12'h302);
               end
               3'b001, 3'b010: begin
                  ctrl.regWrEn = 1'b1;
                  ctrl.wbSel   = WbCsr;
                  ctrl.csrWrEn = 1'b1;
                  ctrl.csrSet  = funct3[1];
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pcUnit import rvPkg::*; #(
   parameter word_t ResetVector = 32'h80000000
) (
   input wire        clk,
   input wire        rst_n,
   decodeIf.dp       ctrl,
   input wire word_t rs1Data_i,
   input wire        aluEq_i,
   input wire        aluLt_i,
   input wire        aluLtu_i,
   input wire        trapTaken_i,
   input wire word_t trapTarget_i,
   output word_t     pc_o
);

   word_t pcReg;
   word_t nextPc;
   word_t jalrSum;
   logic  takeRel;
   logic  isJalr;

   // jal is the pc relative jump, jalr the register based one
   always_comb begin
      case (ctrl.branch)
         BrJump:  takeRel = ctrl.srcAPc;
         BrEq:    takeRel = aluEq_i;
         BrNe:    takeRel = !aluEq_i;
         BrLt:    takeRel = aluLt_i;
         BrGe:    takeRel = !aluLt_i;
         BrLtu:   takeRel = aluLtu_i;
         BrGeu:   takeRel = !aluLtu_i;
         default: takeRel = 1'b0;
      endcase
   end

   assign isJalr  = (ctrl.branch == BrJump) && !ctrl.srcAPc;
   assign jalrSum = rs1Data_i + ctrl.imm;

   always_comb begin
      if (trapTaken_i) nextPc = trapTarget_i;
      else if (takeRel) nextPc = pcReg + ctrl.imm;
      else if (isJalr) nextPc = {jalrSum[31:1], 1'b0};
      else nextPc = pcReg + 32'd4;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) pcReg <= ResetVector;
      else pcReg <= nextPc;
   end

   assign pc_o = pcReg;

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
   input wire        clk,
   input wire        rst_n,
   decodeIf.dp       ctrl,
   input wire word_t wbData_i,
   output word_t     rs1Data_o,
   output word_t     rs2Data_o
);

   word_t regs [0:31];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (rst_n && ctrl.regWrEn && (ctrl.rdAddr != '0)) begin
         regs[ctrl.rdAddr] <= wbData_i;
      end
   end

   // combinational reads, x0 forced to zero
   assign rs1Data_o = (ctrl.rs1Addr == '0) ? '0 : regs[ctrl.rs1Addr];
   assign rs2Data_o = (ctrl.rs2Addr == '0) ? '0 : regs[ctrl.rs2Addr];

endmodule

`default_nettype wire

/* rtl/rvPkg.sv */
`default_nettype none

package rvPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;
   typedef logic [11:0] csrAddr_t;
   typedef logic [3:0]  aluOp_t;
   typedef logic [2:0]  branch_t;
   // write-back source select
   typedef logic [1:0]  wbSel_t;

   // alu operations
   localparam aluOp_t AluAdd   = 4'd0;
   localparam aluOp_t AluSub   = 4'd1;
   localparam aluOp_t AluSll   = 4'd2;
   localparam aluOp_t AluSlt   = 4'd3;
   localparam aluOp_t AluSltu  = 4'd4;
   localparam aluOp_t AluXor   = 4'd5;
   localparam aluOp_t AluSrl   = 4'd6;
   localparam aluOp_t AluSra   = 4'd7;
   localparam aluOp_t AluOr    = 4'd8;
   localparam aluOp_t AluAnd   = 4'd9;
   // lui result comes straight from operand b
   localparam aluOp_t AluPassB = 4'd10;

   // branch conditions, BrJump covers jal and jalr
   localparam branch_t BrNone = 3'd0;
   localparam branch_t BrJump = 3'd1;
   localparam branch_t BrEq   = 3'd2;
   localparam branch_t BrNe   = 3'd3;
   localparam branch_t BrLt   = 3'd4;
   localparam branch_t BrGe   = 3'd5;
   localparam branch_t BrLtu  = 3'd6;
   localparam branch_t BrGeu  = 3'd7;

   localparam wbSel_t WbAlu = 2'd0;
   localparam wbSel_t WbMem = 2'd1;
   localparam wbSel_t WbPc4 = 2'd2;
   localparam wbSel_t WbCsr = 2'd3;

   // machine csr addresses
   localparam csrAddr_t CsrMstatus = 12'h300;
   localparam csrAddr_t CsrMtvec   = 12'h305;
   localparam csrAddr_t CsrMepc    = 12'h341;
   localparam csrAddr_t CsrMcause  = 12'h342;

   localparam word_t CauseEcallM = 32'd11;

endpackage

`default_nettype wire

/* sim/tbCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCore import rvPkg::*; ();

   localparam word_t      ResetVector   = 32'h80000000;
   localparam int         TimeoutCycles = 400;
   localparam int         HandlerIdx    = 48;
   localparam logic [31:0] Seed         = 32'h7475e76f;
   localparam word_t      Nop           = 32'h00000013;
   localparam logic [6:0] OpImm   = 7'b0010011;
   localparam logic [6:0] OpLui   = 7'b0110111;
   localparam logic [6:0] OpAuipc = 7'b0010111;
   localparam logic [6:0] OpLoad  = 7'b0000011;
   localparam logic [6:0] OpJalr  = 7'b1100111;
   // funct3 and alt bit of each tested operation
   localparam logic [2:0] RegF3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
                                          3'd6, 3'd7};
   localparam logic       RegAlt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                          1'b0, 1'b0};
   localparam logic [2:0] ImmF3  [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
   localparam logic       ImmAlt [9]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
   localparam logic [2:0] BrF3   [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

   logic  clk;
   logic  rst_n;
   logic  dmemWr_o;
   word_t instr_i;
   word_t dmemRdata_i;
   word_t instrAddr_o;
   word_t dmemAddr_o;
   word_t dmemWdata_o;
   word_t fetchOff;
   word_t imem [0:255];
   word_t dmem [0:255];
   word_t logAddr [$];
   word_t logData [$];
   word_t expAddr [$];
   word_t expData [$];
   int    progLen = 0;
   int    checkCount = 0;
   int    errorCount = 0;
   int    timeoutCount = 0;

   coreTop i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_i     (instr_i),
      .dmemRdata_i (dmemRdata_i),
      .instrAddr_o (instrAddr_o),
      .dmemAddr_o  (dmemAddr_o),
      .dmemWdata_o (dmemWdata_o),
      .dmemWr_o    (dmemWr_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // memories answer within the cycle
   assign fetchOff    = instrAddr_o - ResetVector;
   assign instr_i     = imem[fetchOff[9:2]];
   assign dmemRdata_i = dmem[dmemAddr_o[9:2]];

   // stores land at the edge ending their cycle
   always @(posedge clk) begin
      if (dmemWr_o === 1'b1) begin
         dmem[dmemAddr_o[9:2]] <= dmemWdata_o;
         logAddr.push_back(dmemAddr_o);
         logData.push_back(dmemWdata_o);
      end
   end

   function automatic word_t fillWord(input word_t addr);
      return addr ^ 32'ha5c3_0f00;
   endfunction

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t rTypeInstr(input logic [6:0] f7, input regAddr_t rs2,
                                        input regAddr_t rs1, input logic [2:0] f3,
                                        input regAddr_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t iTypeInstr(input logic [11:0] imm, input regAddr_t rs1,
                                        input logic [2:0] f3, input regAddr_t rd,
                                        input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t sTypeInstr(input logic [11:0] imm, input regAddr_t rs2,
                                        input regAddr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t bTypeInstr(input logic [12:0] imm, input regAddr_t rs2,
                                        input regAddr_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t uTypeInstr(input logic [19:0] imm, input regAddr_t rd,
                                        input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t jTypeInstr(input logic [20:0] imm, input regAddr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic word_t csrInstr(input csrAddr_t csr, input regAddr_t rs1,
                                      input logic [2:0] f3, input regAddr_t rd);
      return {csr, rs1, f3, rd, 7'b1110011};
   endfunction

   // rv32i result rules
   function automatic word_t expectedAluResult(input logic [2:0] f3, input logic alt,
                                               input word_t a, input word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t curPc();
      return ResetVector + 32'(progLen * 4);
   endfunction

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkAddr(input word_t got, input word_t exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("** Error at %0t ns: %s store address %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic emit(input word_t instr);
      imem[progLen] = instr;
      progLen++;
   endtask

   task automatic expectStore(input word_t addr, input word_t val);
      expAddr.push_back(addr);
      expData.push_back(val);
   endtask

   // store to an absolute address off x0
   task automatic emitStore(input regAddr_t rs2, input logic [11:0] addr, input word_t val);
      emit(sTypeInstr(addr, rs2, 5'd0));
      expectStore(sext12(addr), val);
   endtask

   // lui plus addi, upper part rounded for the signed low part
   task automatic loadConst(input regAddr_t rd, input word_t v);
      word_t hi;
      hi = v + 32'h800;
      emit(uTypeInstr(hi[31:12], rd, OpLui));
      emit(iTypeInstr(v[11:0], rd, 3'd0, rd, OpImm));
   endtask

   task automatic beginProgram();
      int i;
      @(posedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      for (i = 0; i < 256; i++) begin
         imem[i] = Nop;
         dmem[i] = fillWord(32'(i * 4));
      end
      progLen = 0;
      logAddr.delete();
      logData.delete();
      expAddr.delete();
      expData.delete();
   endtask

   task automatic releaseReset();
      int i;
      for (i = 0; i < 3; i++) begin
         @(negedge clk);
         checkFlag(dmemWr_o, 1'b0, "store strobe during reset");
      end
      @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic waitPc(input word_t target, input string what);
      int n;
      for (n = 0; n < TimeoutCycles; n++) begin
         @(negedge clk);
         if (instrAddr_o === target) return;
      end
      timeoutCount++;
      $display("Timeout in %s: fetch never reached address %h", what, target);
   endtask

   task automatic checkStores(input string what);
      int i;
      int n;
      if (logAddr.size() != expAddr.size()) begin
         errorCount++;
         $display("** Error at %0t ns: %s saw %0d stores, expected %0d", $time, what,
                  logAddr.size(), expAddr.size());
      end
      n = (logAddr.size() < expAddr.size()) ? logAddr.size() : expAddr.size();
      for (i = 0; i < n; i++) begin
         checkAddr(logAddr[i], expAddr[i], what);
         checkWord(logData[i], expData[i], $sformatf("%s store %0d data", what, i));
      end
   endtask

   // closes with a jump-to-self and runs until fetch sits there
   task automatic runProgram(input string what);
      word_t endPc;
      endPc = curPc();
      emit(jTypeInstr(21'd0, 5'd0));
      releaseReset();
      waitPc(endPc, what);
      checkStores(what);
   endtask

   task automatic testReset();
      beginProgram();
      emit(Nop);
      emit(Nop);
      emit(jTypeInstr(21'd0, 5'd0));
      // a store sits at the reset vector until reset is released
      imem[0] = sTypeInstr(12'h3f0, 5'd0, 5'd0);
      releaseReset();
      imem[0] = Nop;
      @(negedge clk);
      checkWord(instrAddr_o, ResetVector, "first fetch address");
      checkFlag(dmemWr_o, 1'b0, "store strobe after reset");
      waitPc(ResetVector + 32'd8, "reset");
      checkStores("reset");
   endtask

   task automatic testArithmetic();
      word_t       a;
      word_t       b;
      word_t       pcNow;
      logic [11:0] imm;
      logic [19:0] upper;
      int          k;
      beginProgram();
      a = $urandom();
      b = $urandom();
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      emitStore(5'd1, 12'h100, a);
      emitStore(5'd2, 12'h104, b);
      for (k = 0; k < 10; k++) begin
         emit(rTypeInstr({1'b0, RegAlt[k], 5'b0}, 5'd2, 5'd1, RegF3[k], 5'd3));
         emitStore(5'd3, 12'h110 + 12'(k * 4), expectedAluResult(RegF3[k], RegAlt[k], a, b));
      end
      for (k = 0; k < 9; k++) begin
         imm = 12'($urandom());
         // shifts carry shamt and the arithmetic bit
         if (ImmF3[k] == 3'd1 || ImmF3[k] == 3'd5) imm = {1'b0, ImmAlt[k], 5'b0, imm[4:0]};
         emit(iTypeInstr(imm, 5'd1, ImmF3[k], 5'd4, OpImm));
         emitStore(5'd4, 12'h140 + 12'(k * 4),
                   expectedAluResult(ImmF3[k], ImmAlt[k], a, sext12(imm)));
      end
      upper = 20'($urandom());
      pcNow = curPc();
      emit(uTypeInstr(upper, 5'd6, OpAuipc));
      emitStore(5'd6, 12'h170, pcNow + {upper, 12'b0});
      // writes to x0 are lost
      emit(rTypeInstr(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));
      emit(iTypeInstr(12'h7ff, 5'd1, 3'd0, 5'd0, OpImm));
      emitStore(5'd0, 12'h174, 32'd0);
      runProgram("arithmetic");
   endtask

   task automatic testLoadStore();
      word_t v;
      beginProgram();
      v = $urandom();
      loadConst(5'd1, v);
      emit(iTypeInstr(12'h300, 5'd0, 3'd0, 5'd3, OpImm));
      emit(sTypeInstr(12'd0, 5'd1, 5'd3));
      expectStore(32'h300, v);
      emit(iTypeInstr(12'd0, 5'd3, 3'b010, 5'd2, OpLoad));
      emit(sTypeInstr(12'd8, 5'd2, 5'd3));
      expectStore(32'h308, v);
      // untouched word still holds the fill
      emit(iTypeInstr(12'h310, 5'd0, 3'b010, 5'd4, OpLoad));
      emitStore(5'd4, 12'h30c, fillWord(32'h310));
      runProgram("load/store");
   endtask

   task automatic testBranches();
      word_t       a;
      word_t       b;
      word_t       linkPc;
      logic [11:0] addr;
      int          p;
      int          k;
      beginProgram();
      emit(iTypeInstr(12'h5a5, 5'd0, 3'd0, 5'd5, OpImm));
      for (p = 0; p < 4; p++) begin
         a = $urandom();
         b = $urandom();
         if (p == 1) b = a;
         else if (p == 2) b = a ^ 32'h80000000;
         loadConst(5'd1, a);
         loadConst(5'd2, b);
         for (k = 0; k < 6; k++) begin
            addr = 12'h200 + 12'((p * 6 + k) * 4);
            // taken branch hops over the marker store
            emit(bTypeInstr(13'd8, 5'd2, 5'd1, BrF3[k]));
            emit(sTypeInstr(addr, 5'd5, 5'd0));
            if (!branchTaken(BrF3[k], a, b)) expectStore(sext12(addr), 32'h5a5);
         end
      end
      linkPc = curPc() + 32'd4;
      emit(jTypeInstr(21'd8, 5'd7));
      emit(sTypeInstr(12'h2f0, 5'd5, 5'd0));
      emitStore(5'd7, 12'h2e0, linkPc);
      // odd offset checks bit 0 clearing
      linkPc = curPc() + 32'd8;
      emit(uTypeInstr(20'd0, 5'd8, OpAuipc));
      emit(iTypeInstr(12'd13, 5'd8, 3'd0, 5'd9, OpJalr));
      emit(sTypeInstr(12'h2f4, 5'd5, 5'd0));
      emitStore(5'd9, 12'h2e4, linkPc);
      runProgram("branches");
   endtask

   task automatic testCsrTrap();
      word_t handler;
      word_t r;
      word_t s;
      word_t ecallPc;
      word_t mretPc;
      word_t endPc;
      int    mainIdx;
      beginProgram();
      handler = ResetVector + 32'(HandlerIdx * 4);
      r = $urandom();
      s = $urandom();
      loadConst(5'd1, handler);
      emit(csrInstr(CsrMtvec, 5'd1, 3'b001, 5'd2));
      emitStore(5'd2, 12'h380, 32'd0);
      emit(csrInstr(CsrMtvec, 5'd1, 3'b001, 5'd3));
      emitStore(5'd3, 12'h384, handler);
      loadConst(5'd4, r);
      loadConst(5'd7, s);
      emit(csrInstr(CsrMcause, 5'd4, 3'b010, 5'd5));
      emitStore(5'd5, 12'h388, 32'd0);
      emit(csrInstr(CsrMcause, 5'd7, 3'b010, 5'd6));
      emitStore(5'd6, 12'h38c, r);
      emit(csrInstr(CsrMcause, 5'd0, 3'b010, 5'd8));
      emitStore(5'd8, 12'h390, r | s);
      emit(csrInstr(CsrMstatus, 5'd0, 3'b010, 5'd12));
      emitStore(5'd12, 12'h394, 32'd0);
      ecallPc = curPc();
      emit(32'h00000073);
      // handler placed apart, emitted here to keep stores in run order
      mainIdx = progLen;
      progLen = HandlerIdx;
      emit(csrInstr(CsrMepc, 5'd0, 3'b010, 5'd10));
      emitStore(5'd10, 12'h398, ecallPc);
      emit(csrInstr(CsrMcause, 5'd0, 3'b010, 5'd11));
      emitStore(5'd11, 12'h39c, 32'd11);
      emit(iTypeInstr(12'd4, 5'd10, 3'd0, 5'd10, OpImm));
      emit(csrInstr(CsrMepc, 5'd10, 3'b001, 5'd0));
      mretPc = curPc();
      emit(32'h30200073);
      progLen = mainIdx;
      // MIE back on after mret
      emit(csrInstr(CsrMstatus, 5'd0, 3'b010, 5'd13));
      emitStore(5'd13, 12'h3a0, 32'h8);
      endPc = curPc();
      emit(jTypeInstr(21'd0, 5'd0));
      releaseReset();
      waitPc(ecallPc, "ecall");
      @(negedge clk);
      checkWord(instrAddr_o, handler, "fetch after ecall");
      waitPc(mretPc, "mret");
      @(negedge clk);
      checkWord(instrAddr_o, ecallPc + 32'd4, "fetch after mret");
      waitPc(endPc, "csr/trap");
      checkStores("csr/trap");
   endtask

   initial begin
      rst_n = 1'b0;
      // seed once for the whole run
      void'($urandom(Seed));
      testReset();
      testArithmetic();
      testLoadStore();
      testBranches();
      testCsrTrap();
      $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
rtl/rvPkg.sv
rtl/decodeIf.sv
rtl/instrDecoder.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/csrFile.sv
rtl/pcUnit.sv
rtl/coreTop.sv
sim/tbCore.sv
